/* logic/testchip_pkg.sv */
package testchip_pkg;

    // Word and address geometry of one SRAM bank
    localparam int DATA_W = 32;
    localparam int ADDR_W = 8;
    localparam int MASK_W = 4;
    localparam int DEPTH  = 256;

    // Command packet as it arrives from the analyzer or the GPIO pins.
    // Selects and write enable are active low, as on the macro pins.
    typedef struct packed {
        logic              bank_sel;
        logic              csb0_n;
        logic              web0_n;
        logic [MASK_W-1:0] wmask;
        logic [ADDR_W-1:0] addr0;
        logic [DATA_W-1:0] wdata;
        logic              csb1_n;
        logic [ADDR_W-1:0] addr1;
    } packet_t;

    // Read/write port command, active high
    typedef struct packed {
        logic              en;
        logic              we;
        logic [MASK_W-1:0] wmask;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } rw_cmd_t;

    // Read-only port command
    typedef struct packed {
        logic              en;
        logic [ADDR_W-1:0] addr;
    } ro_cmd_t;

    // Read request that follows the data through the pipeline
    typedef struct packed {
        // Port 0 read
        logic rd0;
        // Port 1 read
        logic rd1;
        logic bank;
    } rd_req_t;

    // Idle values used after reset and for the unselected bank
    localparam rw_cmd_t RW_CMD_IDLE = '{
        en:    1'b0,
        we:    1'b0,
        wmask: '0,
        addr:  '0,
        wdata: '0
    };

    localparam ro_cmd_t RO_CMD_IDLE = '{
        en:   1'b0,
        addr: '0
    };

endpackage

/* logic/packet_decoder.sv */
`timescale 1ns/1ns

module packet_decoder (
    input  logic                  clk_in,
    input  logic                  arst_n,
    input  logic                  in_select,
    input  testchip_pkg::packet_t analyzer_packet,
    input  testchip_pkg::packet_t gpio_packet,
    output testchip_pkg::rw_cmd_t rw_cmd0,
    output testchip_pkg::rw_cmd_t rw_cmd1,
    output testchip_pkg::ro_cmd_t ro_cmd0,
    output testchip_pkg::ro_cmd_t ro_cmd1,
    output testchip_pkg::rd_req_t req
);

    testchip_pkg::packet_t packet;
    testchip_pkg::rw_cmd_t rw_cmd;
    testchip_pkg::ro_cmd_t ro_cmd;
    testchip_pkg::rw_cmd_t rw_cmd0_d;
    testchip_pkg::rw_cmd_t rw_cmd1_d;
    testchip_pkg::ro_cmd_t ro_cmd0_d;
    testchip_pkg::ro_cmd_t ro_cmd1_d;
    testchip_pkg::rd_req_t req_d;
    logic                  rw_en;
    logic                  ro_en;

    // Source select, 0 takes the analyzer
    always_comb begin
        if (in_select) begin
            packet = gpio_packet;
        end else begin
            packet = analyzer_packet;
        end
    end

    assign rw_en = ~packet.csb0_n;
    assign ro_en = ~packet.csb1_n;

    // Active-high form of the packet fields
    always_comb begin
        rw_cmd.en    = rw_en;
        rw_cmd.we    = rw_en & ~packet.web0_n;
        rw_cmd.wmask = packet.wmask;
        rw_cmd.addr  = packet.addr0;
        rw_cmd.wdata = packet.wdata;
        ro_cmd.en    = ro_en;
        ro_cmd.addr  = packet.addr1;
    end

    // Steer enables to the addressed bank
    always_comb begin
        rw_cmd0_d    = rw_cmd;
        rw_cmd1_d    = rw_cmd;
        ro_cmd0_d    = ro_cmd;
        ro_cmd1_d    = ro_cmd;
        rw_cmd0_d.en = rw_cmd.en & ~packet.bank_sel;
        rw_cmd0_d.we = rw_cmd.we & ~packet.bank_sel;
        rw_cmd1_d.en = rw_cmd.en & packet.bank_sel;
        rw_cmd1_d.we = rw_cmd.we & packet.bank_sel;
        ro_cmd0_d.en = ro_cmd.en & ~packet.bank_sel;
        ro_cmd1_d.en = ro_cmd.en & packet.bank_sel;
    end

    // A port 0 access counts as a read only when not writing
    always_comb begin
        req_d.rd0  = rw_en & packet.web0_n;
        req_d.rd1  = ro_en;
        req_d.bank = packet.bank_sel;
    end

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            rw_cmd0 <= testchip_pkg::RW_CMD_IDLE;
            rw_cmd1 <= testchip_pkg::RW_CMD_IDLE;
            ro_cmd0 <= testchip_pkg::RO_CMD_IDLE;
            ro_cmd1 <= testchip_pkg::RO_CMD_IDLE;
            req     <= '0;
        end else begin
            rw_cmd0 <= rw_cmd0_d;
            rw_cmd1 <= rw_cmd1_d;
            ro_cmd0 <= ro_cmd0_d;
            ro_cmd1 <= ro_cmd1_d;
            req     <= req_d;
        end
    end

endmodule

/* logic/sram_1rw1r_model.sv */
`timescale 1ns/1ns

module sram_1rw1r_model (
    input  logic                              clk_in,
    input  testchip_pkg::rw_cmd_t             rw_cmd,
    input  testchip_pkg::ro_cmd_t             ro_cmd,
    output logic [testchip_pkg::DATA_W-1:0]   dout0,
    output logic [testchip_pkg::DATA_W-1:0]   dout1
);

    localparam int BYTE_W = testchip_pkg::DATA_W / testchip_pkg::MASK_W;

    logic [testchip_pkg::DATA_W-1:0] mem [0:testchip_pkg::DEPTH-1];
    logic [testchip_pkg::DATA_W-1:0] wr_word;
    logic [testchip_pkg::DATA_W-1:0] old_word;
    logic                            rd0_en;
    logic                            wr_en;

    assign wr_en  = rw_cmd.en & rw_cmd.we;
    assign rd0_en = rw_cmd.en & ~rw_cmd.we;

    // Current contents at the port 0 address
    assign old_word = mem[rw_cmd.addr];

    // Merge write data into the old word lane by lane
    always_comb begin
        wr_word = old_word;
        for (int i = 0; i < testchip_pkg::MASK_W; i++) begin
            if (rw_cmd.wmask[i]) begin
                wr_word[i*BYTE_W +: BYTE_W] = rw_cmd.wdata[i*BYTE_W +: BYTE_W];
            end
        end
    end

    // Port 0 write
    always_ff @(posedge clk_in) begin
        if (wr_en) begin
            mem[rw_cmd.addr] <= wr_word;
        end
    end

    // Port 0 read, holds when idle or writing
    always_ff @(posedge clk_in) begin
        if (rd0_en) begin
            dout0 <= mem[rw_cmd.addr];
        end
    end

    // Port 1 read.
    // Nonblocking update above means a same-edge write is not yet visible here,
    // so a colliding read returns the old word
    always_ff @(posedge clk_in) begin
        if (ro_cmd.en) begin
            dout1 <= mem[ro_cmd.addr];
        end
    end

endmodule

/* logic/read_port_select.sv */
`timescale 1ns/1ns

module read_port_select (
    input  logic                            clk_in,
    input  logic                            arst_n,
    input  testchip_pkg::rd_req_t           req,
    input  logic [testchip_pkg::DATA_W-1:0] dout0,
    input  logic [testchip_pkg::DATA_W-1:0] dout1,
    output logic [testchip_pkg::DATA_W-1:0] bank_data,
    output testchip_pkg::rd_req_t           bank_req
);

    testchip_pkg::rd_req_t req_q;

    // Delay the request by one cycle to meet the SRAM output
    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            req_q <= '0;
        end else begin
            req_q <= req;
        end
    end

    // Port 0 wins when both ports read
    always_comb begin
        if (req_q.rd0) begin
            bank_data = dout0;
        end else begin
            bank_data = dout1;
        end
    end

    assign bank_req = req_q;

endmodule

/* logic/bank_output_select.sv */
`timescale 1ns/1ns

module bank_output_select (
    input  logic                            clk_in,
    input  logic                            arst_n,
    input  logic [testchip_pkg::DATA_W-1:0] bank_data0,
    input  logic [testchip_pkg::DATA_W-1:0] bank_data1,
    input  testchip_pkg::rd_req_t           bank_req,
    output logic [testchip_pkg::DATA_W-1:0] sram_data,
    output logic                            rd_valid
);

    logic [testchip_pkg::DATA_W-1:0] read_data;
    logic                            any_rd;

    assign any_rd = bank_req.rd0 | bank_req.rd1;

    // Bank select
    always_comb begin
        if (bank_req.bank) begin
            read_data = bank_data1;
        end else begin
            read_data = bank_data0;
        end
    end

    // sram_data keeps the last read word between reads
    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            sram_data <= '0;
            rd_valid  <= 1'b0;
        end else begin
            rd_valid <= any_rd;
            if (any_rd) begin
                sram_data <= read_data;
            end
        end
    end

endmodule

/* logic/openram_testchip.sv */
`timescale 1ns/1ns

module openram_testchip (
    input  logic                            clk_in,
    input  logic                            arst_n,
    input  logic                            in_select,
    input  testchip_pkg::packet_t           analyzer_packet,
    input  testchip_pkg::packet_t           gpio_packet,
    output logic [testchip_pkg::DATA_W-1:0] sram_data,
    output logic                            rd_valid
);

    testchip_pkg::rw_cmd_t           rw_cmd0;
    testchip_pkg::rw_cmd_t           rw_cmd1;
    testchip_pkg::ro_cmd_t           ro_cmd0;
    testchip_pkg::ro_cmd_t           ro_cmd1;
    testchip_pkg::rd_req_t           req;
    testchip_pkg::rd_req_t           bank_req;

    logic [testchip_pkg::DATA_W-1:0] sram0_dout0;
    logic [testchip_pkg::DATA_W-1:0] sram0_dout1;
    logic [testchip_pkg::DATA_W-1:0] sram1_dout0;
    logic [testchip_pkg::DATA_W-1:0] sram1_dout1;
    logic [testchip_pkg::DATA_W-1:0] bank_data0;
    logic [testchip_pkg::DATA_W-1:0] bank_data1;

    packet_decoder u_decoder (
        .clk_in          (clk_in),
        .arst_n          (arst_n),
        .in_select       (in_select),
        .analyzer_packet (analyzer_packet),
        .gpio_packet     (gpio_packet),
        .rw_cmd0         (rw_cmd0),
        .rw_cmd1         (rw_cmd1),
        .ro_cmd0         (ro_cmd0),
        .ro_cmd1         (ro_cmd1),
        .req             (req)
    );

    sram_1rw1r_model sram_0 (
        .clk_in (clk_in),
        .rw_cmd (rw_cmd0),
        .ro_cmd (ro_cmd0),
        .dout0  (sram0_dout0),
        .dout1  (sram0_dout1)
    );

    sram_1rw1r_model sram_1 (
        .clk_in (clk_in),
        .rw_cmd (rw_cmd1),
        .ro_cmd (ro_cmd1),
        .dout0  (sram1_dout0),
        .dout1  (sram1_dout1)
    );

    read_port_select u_rd_sel0 (
        .clk_in    (clk_in),
        .arst_n    (arst_n),
        .req       (req),
        .dout0     (sram0_dout0),
        .dout1     (sram0_dout1),
        .bank_data (bank_data0),
        .bank_req  (bank_req)
    );

    // Same request as bank 0, so its copy is left open
    read_port_select u_rd_sel1 (
        .clk_in    (clk_in),
        .arst_n    (arst_n),
        .req       (req),
        .dout0     (sram1_dout0),
        .dout1     (sram1_dout1),
        .bank_data (bank_data1),
        .bank_req  ()
    );

    bank_output_select u_out_sel (
        .clk_in     (clk_in),
        .arst_n     (arst_n),
        .bank_data0 (bank_data0),
        .bank_data1 (bank_data1),
        .bank_req   (bank_req),
        .sram_data  (sram_data),
        .rd_valid   (rd_valid)
    );

endmodule

/* dv/tb_openram_testchip.sv */
`timescale 1ns/1ns

module tb_openram_testchip;

    localparam int DRAIN_LIMIT = 16;
    localparam int DATA_W      = testchip_pkg::DATA_W;
    localparam int ADDR_W      = testchip_pkg::ADDR_W;
    localparam int MASK_W      = testchip_pkg::MASK_W;

    // One expected output sample due at a given cycle count
    typedef struct packed {
        logic [31:0]       due;
        logic              valid;
        logic [DATA_W-1:0] data;
    } expect_t;

    logic                  clk_in;
    logic                  arst_n;
    logic                  in_select;
    testchip_pkg::packet_t analyzer_packet;
    testchip_pkg::packet_t gpio_packet;
    logic [DATA_W-1:0]     sram_data;
    logic                  rd_valid;

    logic [DATA_W-1:0]     ref_mem [0:1][0:testchip_pkg::DEPTH-1];
    logic [DATA_W-1:0]     last_data;
    expect_t               exp_q [$];
    logic [31:0]           cycle;
    integer                seed;
    string                 test_name;
    int                    test_errors;
    int                    total_checks;
    int                    tests_run;
    int                    tests_failed;
    logic                  timed_out;
    logic                  src_sel;

    openram_testchip DUT (
        .clk_in          (clk_in),
        .arst_n          (arst_n),
        .in_select       (in_select),
        .analyzer_packet (analyzer_packet),
        .gpio_packet     (gpio_packet),
        .sram_data       (sram_data),
        .rd_valid        (rd_valid)
    );

    initial begin
        clk_in = 1'b0;
        forever #4 clk_in = ~clk_in;
    end

    function automatic testchip_pkg::packet_t build_packet(
        input logic              bank,
        input logic              csb0_n,
        input logic              web0_n,
        input logic [MASK_W-1:0] wmask,
        input logic [ADDR_W-1:0] addr0,
        input logic [DATA_W-1:0] wdata,
        input logic              csb1_n,
        input logic [ADDR_W-1:0] addr1
    );
        testchip_pkg::packet_t p;
        p.bank_sel = bank;
        p.csb0_n   = csb0_n;
        p.web0_n   = web0_n;
        p.wmask    = wmask;
        p.addr0    = addr0;
        p.wdata    = wdata;
        p.csb1_n   = csb1_n;
        p.addr1    = addr1;
        return p;
    endfunction

    function automatic testchip_pkg::packet_t idle_packet();
        return build_packet(1'b0, 1'b1, 1'b1, '0, '0, '0, 1'b1, '0);
    endfunction

    task automatic check_outputs();
        expect_t e;
        while (exp_q.size() > 0 && exp_q[0].due == cycle) begin
            e = exp_q.pop_front();
            total_checks++;
            assert (rd_valid === e.valid) else begin
                $display("Mismatch in %s: rd_valid expected %0b, actual %0b",
                         test_name, e.valid, rd_valid);
                test_errors++;
            end
            assert (sram_data === e.data) else begin
                $display("Mismatch in %s: sram_data expected %h, actual %h",
                         test_name, e.data, sram_data);
                test_errors++;
            end
        end
    endtask

    // Advance to 1 ns after the next rising edge
    task automatic tick();
        @(posedge clk_in);
        cycle = cycle + 1;
        #1;
        check_outputs();
    endtask

    // Reference memory with read before write and byte-masked writes
    task automatic model_packet(input testchip_pkg::packet_t pkt);
        expect_t           e;
        int                b;
        int                i;
        logic [DATA_W-1:0] word;
        b       = pkt.bank_sel;
        e.due   = cycle + 3;
        e.valid = 1'b0;
        e.data  = last_data;
        if (!pkt.csb0_n && pkt.web0_n) begin
            e.valid = 1'b1;
            e.data  = ref_mem[b][pkt.addr0];
        end else if (!pkt.csb1_n) begin
            e.valid = 1'b1;
            e.data  = ref_mem[b][pkt.addr1];
        end
        last_data = e.data;
        exp_q.push_back(e);
        if (!pkt.csb0_n && !pkt.web0_n) begin
            word = ref_mem[b][pkt.addr0];
            for (i = 0; i < MASK_W; i++) begin
                if (pkt.wmask[i]) begin
                    word[i*8 +: 8] = pkt.wdata[i*8 +: 8];
                end
            end
            ref_mem[b][pkt.addr0] = word;
        end
    endtask

    // Other packet goes to the unselected source
    task automatic send_packet(input testchip_pkg::packet_t pkt,
                               input testchip_pkg::packet_t other);
        in_select = src_sel;
        if (src_sel) begin
            gpio_packet     = pkt;
            analyzer_packet = other;
        end else begin
            analyzer_packet = pkt;
            gpio_packet     = other;
        end
        model_packet(pkt);
        tick();
    endtask

    task automatic send(input testchip_pkg::packet_t pkt);
        send_packet(pkt, idle_packet());
    endtask

    task automatic write_word(input logic bank, input logic [ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] data,
                              input logic [MASK_W-1:0] mask);
        send(build_packet(bank, 1'b0, 1'b0, mask, addr, data, 1'b1, '0));
    endtask

    task automatic read_port0(input logic bank, input logic [ADDR_W-1:0] addr);
        send(build_packet(bank, 1'b0, 1'b1, '0, addr, '0, 1'b1, '0));
    endtask

    task automatic read_port1(input logic bank, input logic [ADDR_W-1:0] addr);
        send(build_packet(bank, 1'b1, 1'b1, '0, '0, '0, 1'b0, addr));
    endtask

    task automatic drain_pipeline();
        int wait_cnt;
        in_select       = src_sel;
        analyzer_packet = idle_packet();
        gpio_packet     = idle_packet();
        wait_cnt        = 0;
        while (exp_q.size() > 0 && wait_cnt < DRAIN_LIMIT) begin
            tick();
            wait_cnt++;
        end
        if (exp_q.size() > 0) begin
            $display("Timeout in %s: pipeline did not drain", test_name);
            test_errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic apply_reset();
        arst_n = 1'b0;
        repeat (2) @(posedge clk_in);
        #1;
        arst_n    = 1'b1;
        cycle     = 0;
        last_data = '0;
        exp_q.delete();
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        drain_pipeline();
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
            $display("FAIL %s (%0d errors)", test_name, test_errors);
        end else begin
            $display("PASS %s", test_name);
        end
    endtask

    task automatic reset_state();
        start_test("reset");
        total_checks++;
        assert (sram_data === '0 && rd_valid === 1'b0) else begin
            $display("Mismatch in %s: expected sram_data 0 rd_valid 0, actual %h %0b",
                     test_name, sram_data, rd_valid);
            test_errors++;
        end
        repeat (6) send(idle_packet());
        end_test();
    endtask

    task automatic full_word_rw();
        int i;
        start_test("full_word");
        for (i = 0; i < 8; i++) begin
            write_word(1'b0, i, $random(seed), 4'hf);
            write_word(1'b1, i, $random(seed), 4'hf);
        end
        for (i = 0; i < 8; i++) begin
            read_port0(1'b0, i);
            read_port0(1'b1, i);
        end
        // Same address in both banks stays separate
        write_word(1'b0, 8'h40, 32'h1111_0000, 4'hf);
        write_word(1'b1, 8'h40, 32'h2222_0000, 4'hf);
        read_port0(1'b0, 8'h40);
        write_word(1'b1, 8'h40, 32'h3333_0000, 4'hf);
        read_port0(1'b1, 8'h40);
        read_port0(1'b0, 8'h40);
        end_test();
    endtask

    task automatic byte_mask_writes();
        int m;
        int b;
        start_test("byte_mask");
        for (b = 0; b < 2; b++) begin
            write_word(b, 8'h80, 32'h0123_4567, 4'hf);
            for (m = 0; m < 16; m++) begin
                write_word(b, 8'h80, $random(seed), m);
                read_port0(b, 8'h80);
            end
        end
        end_test();
    endtask

    task automatic port1_reads();
        int i;
        start_test("port1");
        for (i = 0; i < 4; i++) begin
            write_word(1'b1, 8'hc0 + i, $random(seed), 4'hf);
            write_word(1'b0, 8'hc0 + i, $random(seed), 4'hf);
        end
        for (i = 0; i < 4; i++) begin
            read_port1(1'b1, 8'hc0 + i);
            read_port1(1'b0, 8'hc0 + i);
        end
        // Both ports read and port 0 has priority
        send(build_packet(1'b1, 1'b0, 1'b1, '0, 8'hc0, '0, 1'b0, 8'hc1));
        send(build_packet(1'b0, 1'b0, 1'b1, '0, 8'hc3, '0, 1'b0, 8'hc2));
        // Write and port 1 read of one address in one packet
        send(build_packet(1'b1, 1'b0, 1'b0, 4'hf, 8'hc2, 32'hdead_beef, 1'b0, 8'hc2));
        read_port1(1'b1, 8'hc2);
        send(build_packet(1'b0, 1'b0, 1'b0, 4'h3, 8'hc1, 32'hcafe_f00d, 1'b0, 8'hc1));
        read_port1(1'b0, 8'hc1);
        end_test();
    endtask

    task automatic source_select();
        start_test("source_select");
        src_sel = 1'b1;
        send_packet(build_packet(1'b0, 1'b0, 1'b0, 4'hf, 8'h20, 32'h6000_0001, 1'b1, '0),
                    build_packet(1'b0, 1'b0, 1'b0, 4'hf, 8'h20, 32'hbad0_0001, 1'b1, '0));
        send_packet(build_packet(1'b0, 1'b0, 1'b1, '0, 8'h20, '0, 1'b1, '0),
                    build_packet(1'b0, 1'b0, 1'b0, 4'hf, 8'h20, 32'hbad0_0002, 1'b1, '0));
        read_port0(1'b0, 8'h20);
        // Unselected read must not raise rd_valid
        send_packet(idle_packet(),
                    build_packet(1'b1, 1'b0, 1'b1, '0, 8'h20, '0, 1'b0, 8'h21));
        src_sel = 1'b0;
        send_packet(build_packet(1'b1, 1'b0, 1'b0, 4'hf, 8'h21, 32'ha000_0021, 1'b1, '0),
                    build_packet(1'b1, 1'b0, 1'b0, 4'hf, 8'h21, 32'hbad0_0021, 1'b1, '0));
        send_packet(build_packet(1'b1, 1'b1, 1'b1, '0, '0, '0, 1'b0, 8'h21),
                    build_packet(1'b1, 1'b0, 1'b0, 4'hf, 8'h21, 32'hbad0_0022, 1'b1, '0));
        read_port0(1'b1, 8'h21);
        send_packet(idle_packet(),
                    build_packet(1'b0, 1'b0, 1'b1, '0, 8'h20, '0, 1'b1, '0));
        end_test();
    endtask

    task automatic random_stream();
        testchip_pkg::packet_t pkt;
        testchip_pkg::packet_t other;
        logic [31:0]           r;
        logic [31:0]           d;
        int                    b;
        int                    a;
        int                    n;
        start_test("random");
        for (b = 0; b < 2; b++) begin
            for (a = 0; a < testchip_pkg::DEPTH; a++) begin
                write_word(b, a, $random(seed), 4'hf);
            end
        end
        for (n = 0; n < 200; n++) begin
            r = $random(seed);
            d = $random(seed);
            if (r[27:25] == 3'd0) begin
                pkt = idle_packet();
            end else begin
                pkt = build_packet(r[24], r[0], r[1], r[7:4], r[15:8], d, r[2], r[23:16]);
            end
            r       = $random(seed);
            d       = $random(seed);
            other   = build_packet(r[24], r[0], r[1], r[7:4], r[15:8], d, r[2], r[23:16]);
            src_sel = r[28];
            send_packet(pkt, other);
        end
        src_sel = 1'b0;
        end_test();
    endtask

    initial begin
        seed            = 32'had5cd424;
        arst_n          = 1'b0;
        in_select       = 1'b0;
        analyzer_packet = idle_packet();
        gpio_packet     = idle_packet();
        src_sel         = 1'b0;
        timed_out       = 1'b0;
        cycle           = 0;
        last_data       = '0;
        test_name       = "none";
        test_errors     = 0;
        total_checks    = 0;
        tests_run       = 0;
        tests_failed    = 0;
        apply_reset();
        reset_state();
        if (!timed_out) begin
            full_word_rw();
        end
        if (!timed_out) begin
            byte_mask_writes();
        end
        if (!timed_out) begin
            port1_reads();
        end
        if (!timed_out) begin
            source_select();
        end
        if (!timed_out) begin
            random_stream();
        end
        $display("Summary: %0d tests run, %0d passed, %0d failed, %0d checks",
                 tests_run, tests_run - tests_failed, tests_failed, total_checks);
        if (tests_failed == 0 && !timed_out) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* verilog.f */
logic/testchip_pkg.sv
logic/packet_decoder.sv
logic/sram_1rw1r_model.sv
logic/read_port_select.sv
logic/bank_output_select.sv
logic/openram_testchip.sv
dv/tb_openram_testchip.sv
